//--- include/wbm_settings.svh
// shared settings of the host to wishbone bridge
// word width, fifo depth, bus timeout, write marker and host flow thresholds
`ifndef WBM_SETTINGS_SVH
`define WBM_SETTINGS_SVH

`define WBM_WORD_W        32            // data and address width of host and bus
`define WBM_FIFO_DEPTH    64            // depth of the input and the output fifo in words
`define WBM_TIMEOUT       100           // strobe cycles without ack before an access is dropped

// data word returned in place of read data for a plain write
`define WBM_WRITE_MARK    32'hdeadbeef

`define WBM_READY_SLACK   8             // ready_o drops once free input slots reach this
`define WBM_PACKET_WORDS  4             // command and response packets are both four words

`endif

//--- rtl/wbm_pkg.sv
// types shared by the bridge stages
// operation code, command word layout, request and response payloads
`include "wbm_settings.svh"

package wbm_pkg;

   typedef logic [`WBM_WORD_W-1:0] word_t;

   // operation code in the two low bits of the command word
   typedef enum logic [1:0] {
      OP_READ  = 2'd0,
      OP_WRITE = 2'd1,
      OP_RMW   = 2'd2,                  // read, merge under mask, write back
      OP_RSVD  = 2'd3                   // reserved code, runs as a read
   } op_e;

   // command word as the host sends it
   // only op is decoded, the rest goes back to the host untouched
   typedef struct packed {
      logic [8:0]  upper;               // bits 31:23, echoed
      logic [7:0]  id;                  // bits 22:15, transaction id for the host
      logic [12:0] spare;               // bits 14:2, echoed
      op_e         op;                  // bits 1:0
   } cmd_t;

   // one command packet, fields in arrival order
   typedef struct packed {
      cmd_t  cmd;
      word_t addr;
      word_t mask;                      // only used by read-modify-write
      word_t data;
   } request_t;

   // one result from the bus engine before it is split into words
   typedef struct packed {
      cmd_t  cmd;
      word_t data;
      word_t addr;
      logic  timeout;                   // set when the target never answered
   } response_t;

endpackage

//--- rtl/stage_if.sv
// four-phase req/ack link between two pipeline stages
// payload type is a parameter, sender and receiver modports
`timescale 1ns/100ps

interface stage_if #(
   parameter type payload_t = logic
);

   logic     req;                       // raised by the sender with payload stable
   logic     ack;                       // raised by the receiver once payload is taken
   payload_t payload;

   // sender holds req until ack, then waits for ack low before the next item
   modport sender (
      output req,
      output payload,
      input  ack
   );

   modport receiver (
      input  req,
      input  payload,
      output ack
   );

endinterface

//--- rtl/word_fifo.sv
// synchronous fifo with first-word-fall-through read port
// occupancy count output for the host flow flags
`timescale 1ns/100ps

module word_fifo #(
   parameter type payload_t = logic,
   parameter int  DEPTH     = 16
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       wr_en_i,
   input  payload_t                   wr_data_i,
   input  logic                       rd_en_i,
   output payload_t                   rd_data_o,
   output logic                       empty_o,
   output logic                       full_o,
   output logic [$clog2(DEPTH+1)-1:0] level_o
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic             wr_ok;             // write really taken, full drops it
   logic             rd_ok;             // read really taken, empty drops it

   // pointer step with wrap, depth need not be a power of two
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign wr_ok     = wr_en_i && !full_o;
   assign rd_ok     = rd_en_i && !empty_o;
   assign empty_o   = (level_o == '0);
   assign full_o    = (level_o == DEPTH);
   assign rd_data_o = mem[rd_ptr];      // head word is visible before the read strobe

   always_ff @(posedge clk) begin
      if (wr_ok) begin
         mem[wr_ptr] <= wr_data_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         level_o <= '0;
      end else begin
         if (wr_ok) wr_ptr <= next_ptr(wr_ptr);
         if (rd_ok) rd_ptr <= next_ptr(rd_ptr);
         case ({wr_ok, rd_ok})
            2'b10:   level_o <= level_o + 1'b1;
            2'b01:   level_o <= level_o - 1'b1;
            default: level_o <= level_o;  // no change, or one in and one out
         endcase
      end
   end

   // a write strobe while full must not move the write side
   a_no_write_when_full : assert property (@(posedge clk) disable iff (rst)
      (full_o && !rd_en_i) |=> ($stable(wr_ptr) && full_o));

endmodule

//--- rtl/command_parser.sv
// first pipeline stage
// pulls four words from the input fifo and offers them as one request
`timescale 1ns/100ps
`include "wbm_settings.svh"

module command_parser (
   input  logic          clk,
   input  logic          rst,
   input  wbm_pkg::word_t fifo_data_i,
   input  logic          fifo_empty_i,
   output logic          fifo_rd_o,
   stage_if.sender       req_o
);

   import wbm_pkg::*;

   localparam int CNT_W = $clog2(`WBM_PACKET_WORDS);
   localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(`WBM_PACKET_WORDS - 1);

   logic [CNT_W-1:0] cnt;               // position of the next word in the packet
   logic             holding;           // full packet held until the handshake closes
   request_t         pkt;

   // one word per cycle while a word is there and no packet is held
   assign fifo_rd_o     = !fifo_empty_i && !holding;
   assign req_o.payload = pkt;

   // --------------------------------------------------
   // word counter and sender side of the handshake
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         cnt       <= '0;
         holding   <= 1'b0;
         req_o.req <= 1'b0;
      end else begin
         if (fifo_rd_o) begin
            cnt <= (cnt == LAST_WORD) ? '0 : cnt + 1'b1;
            if (cnt == LAST_WORD) begin
               holding   <= 1'b1;       // req goes up the cycle after the last word
               req_o.req <= 1'b1;
            end
         end
         if (req_o.req && req_o.ack) req_o.req <= 1'b0;
         // free only after ack fell, so req cannot rise into a stale ack
         if (holding && !req_o.req && !req_o.ack) holding <= 1'b0;
      end
   end

   // steer each word into its field
   always_ff @(posedge clk) begin
      if (fifo_rd_o) begin
         case (cnt)
            0:       pkt.cmd  <= cmd_t'(fifo_data_i);
            1:       pkt.addr <= fifo_data_i;
            2:       pkt.mask <= fifo_data_i;
            default: pkt.data <= fifo_data_i;
         endcase
      end
   end

   // the engine samples the payload at some point while req is up
   a_req_held_stable : assert property (@(posedge clk) disable iff (rst)
      (req_o.req && !req_o.ack) |=> (req_o.req && $stable(req_o.payload)));

endmodule

//--- rtl/bus_engine.sv
// second pipeline stage
// wishbone classic single cycle master with timeout
// read, write and read-modify-write with mask merge
`timescale 1ns/100ps
`include "wbm_settings.svh"

module bus_engine (
   input  logic           clk,
   input  logic           rst,
   stage_if.receiver      req_i,
   stage_if.sender        rsp_o,
   output logic           wb_cyc_o,
   output logic           wb_stb_o,
   output logic           wb_we_o,
   output wbm_pkg::word_t wb_adr_o,
   output wbm_pkg::word_t wb_dat_o,
   input  wbm_pkg::word_t wb_dat_i,
   input  logic           wb_ack_i
);

   import wbm_pkg::*;

   localparam int TMO_W = $clog2(`WBM_TIMEOUT + 1);

   typedef enum logic [2:0] {
      ST_IDLE,                          // waiting for a request
      ST_ACCESS,                        // first bus access, the only one unless rmw
      ST_MERGE,                         // builds the rmw write word
      ST_ACCESS2,                       // write back of the merged word
      ST_RESPOND                        // response handshake toward the packer
   } state_e;

   state_e           state;
   request_t         cur;               // request being executed
   word_t            old_word;          // read data, zero after a timeout
   logic             timed_out;
   logic [TMO_W-1:0] tmo_cnt;           // strobe cycles without ack
   logic             tmo_hit;
   logic             is_write;
   logic             is_rmw;

   assign is_write = (cur.cmd.op == OP_WRITE);
   assign is_rmw   = (cur.cmd.op == OP_RMW);
   assign tmo_hit  = (tmo_cnt == TMO_W'(`WBM_TIMEOUT - 1));

   // writes report the marker, reads and rmw the word that was on the bus
   assign rsp_o.payload = response_t'{
      cmd:     cur.cmd,
      data:    is_write ? `WBM_WRITE_MARK : old_word,
      addr:    cur.addr,
      timeout: timed_out
   };

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= ST_IDLE;
         req_i.ack <= 1'b0;
         rsp_o.req <= 1'b0;
         wb_cyc_o  <= 1'b0;
         wb_stb_o  <= 1'b0;
         wb_we_o   <= 1'b0;
         tmo_cnt   <= '0;
         timed_out <= 1'b0;
      end else begin
         if (req_i.ack && !req_i.req) req_i.ack <= 1'b0;   // phase four toward the parser
         case (state)
            ST_IDLE: begin
               if (req_i.req && !req_i.ack) begin
                  cur       <= req_i.payload;
                  req_i.ack <= 1'b1;
                  timed_out <= 1'b0;
                  tmo_cnt   <= '0;
                  wb_cyc_o  <= 1'b1;                       // bus starts right after capture
                  wb_stb_o  <= 1'b1;
                  wb_we_o   <= (req_i.payload.cmd.op == OP_WRITE);   // reserved code reads
                  wb_adr_o  <= req_i.payload.addr;
                  wb_dat_o  <= req_i.payload.data;
                  state     <= ST_ACCESS;
               end
            end
            ST_ACCESS, ST_ACCESS2: begin
               tmo_cnt <= tmo_cnt + 1'b1;
               if (wb_ack_i || tmo_hit) begin
                  wb_cyc_o  <= 1'b0;
                  wb_stb_o  <= 1'b0;
                  wb_we_o   <= 1'b0;
                  tmo_cnt   <= '0;
                  timed_out <= !wb_ack_i;
                  if (state == ST_ACCESS) old_word <= wb_ack_i ? wb_dat_i : '0;
                  // rmw writes back only if its read was answered
                  if (state == ST_ACCESS && is_rmw && wb_ack_i) begin
                     state <= ST_MERGE;
                  end else begin
                     rsp_o.req <= 1'b1;
                     state     <= ST_RESPOND;
                  end
               end
            end
            ST_MERGE: begin
               wb_cyc_o <= 1'b1;
               wb_stb_o <= 1'b1;
               wb_we_o  <= 1'b1;
               wb_dat_o <= (old_word & ~cur.mask) | (cur.data & cur.mask);
               state    <= ST_ACCESS2;
            end
            default: begin
               if (rsp_o.req && rsp_o.ack) rsp_o.req <= 1'b0;
               if (!rsp_o.req && !rsp_o.ack) state <= ST_IDLE;   // packer released its ack
            end
         endcase
      end
   end

   a_stb_needs_cyc : assert property (@(posedge clk) disable iff (rst)
      wb_stb_o |-> wb_cyc_o);

   // the timeout bounds every bus cycle
   a_cyc_bounded : assert property (@(posedge clk) disable iff (rst)
      $rose(wb_cyc_o) |-> ##[1:`WBM_TIMEOUT + 1] !wb_cyc_o);

endmodule

//--- rtl/response_packer.sv
// last pipeline stage
// splits one response into four words for the output fifo
`timescale 1ns/100ps
`include "wbm_settings.svh"

module response_packer #(
   parameter int DEPTH = 64
) (
   input  logic                       clk,
   input  logic                       rst,
   stage_if.receiver                  rsp_i,
   input  logic [$clog2(DEPTH+1)-1:0] fifo_level_i,
   output logic                       fifo_wr_o,
   output wbm_pkg::word_t             fifo_data_o
);

   import wbm_pkg::*;

   localparam int CNT_W = $clog2(`WBM_PACKET_WORDS);
   localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(`WBM_PACKET_WORDS - 1);

   response_t        held;
   logic             busy;              // a packet is being written out
   logic [CNT_W-1:0] cnt;
   logic             room;
   logic             take;

   // level is exact here since writes are not registered
   assign room      = (fifo_level_i <= DEPTH - `WBM_PACKET_WORDS);
   assign take      = rsp_i.req && !rsp_i.ack && !busy && room;
   assign fifo_wr_o = busy;

   // word order is command, data, address, result
   always_comb begin
      case (cnt)
         0:       fifo_data_o = held.cmd;
         1:       fifo_data_o = held.data;
         2:       fifo_data_o = held.addr;
         default: fifo_data_o = word_t'(held.timeout);   // timeout in bit 0, zeros above
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         busy      <= 1'b0;
         cnt       <= '0;
         rsp_i.ack <= 1'b0;
      end else begin
         if (take) begin
            rsp_i.ack <= 1'b1;          // held back while the output fifo is short of room
            busy      <= 1'b1;
            cnt       <= '0;
         end
         if (rsp_i.ack && !rsp_i.req) rsp_i.ack <= 1'b0;
         if (busy) begin
            cnt <= cnt + 1'b1;
            if (cnt == LAST_WORD) busy <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take) held <= rsp_i.payload;
   end

endmodule

//--- rtl/wb_bridge_top.sv
// host word stream to wishbone master bridge
// input fifo, parser, bus engine, packer, output fifo
// ready and available flags toward the host
`timescale 1ns/100ps
`include "wbm_settings.svh"

module wb_bridge_top (
   input  logic           clk,
   input  logic           rst,
   input  logic           wr_i,
   input  wbm_pkg::word_t data_i,
   output logic           ready_o,
   input  logic           rd_i,
   output wbm_pkg::word_t data_o,
   output logic           avail_o,
   output logic           wb_cyc_o,
   output logic           wb_stb_o,
   output logic           wb_we_o,
   output wbm_pkg::word_t wb_adr_o,
   output wbm_pkg::word_t wb_dat_o,
   input  wbm_pkg::word_t wb_dat_i,
   input  logic           wb_ack_i
);

   import wbm_pkg::*;

   localparam int DEPTH   = `WBM_FIFO_DEPTH;
   localparam int LEVEL_W = $clog2(DEPTH + 1);

   word_t              in_data;
   logic               in_empty;
   logic               in_rd;
   logic [LEVEL_W-1:0] in_level;
   word_t              out_head;        // fall-through head of the output fifo
   word_t              pk_data;
   logic               pk_wr;
   logic [LEVEL_W-1:0] out_level;

   stage_if #(.payload_t(request_t))  req_link ();
   stage_if #(.payload_t(response_t)) rsp_link ();

   // --------------------------------------------------
   // host side
   // --------------------------------------------------
   word_fifo #(.payload_t(word_t), .DEPTH(DEPTH)) in_fifo (
      .clk, .rst,
      .wr_en_i (wr_i),     .wr_data_i (data_i),
      .rd_en_i (in_rd),    .rd_data_o (in_data),
      .empty_o (in_empty), .full_o (), .level_o (in_level)
   );

   word_fifo #(.payload_t(word_t), .DEPTH(DEPTH)) out_fifo (
      .clk, .rst,
      .wr_en_i (pk_wr),  .wr_data_i (pk_data),
      .rd_en_i (rd_i),   .rd_data_o (out_head),
      .empty_o (),       .full_o (), .level_o (out_level)
   );

   // registered so it stays low through reset, slack covers the lag
   always_ff @(posedge clk) begin
      if (rst) ready_o <= 1'b0;
      else     ready_o <= (DEPTH - in_level) > `WBM_READY_SLACK;
   end

   // read word shows up one cycle after the rd_i pulse
   always_ff @(posedge clk) begin
      if (rd_i) data_o <= out_head;
   end

   assign avail_o = (out_level >= `WBM_PACKET_WORDS);   // at least one whole packet

   // --------------------------------------------------
   // pipeline stages
   // --------------------------------------------------
   command_parser parser (
      .clk, .rst,
      .fifo_data_i (in_data), .fifo_empty_i (in_empty), .fifo_rd_o (in_rd),
      .req_o       (req_link.sender)
   );

   bus_engine engine (
      .clk, .rst,
      .req_i (req_link.receiver), .rsp_o (rsp_link.sender),
      .wb_cyc_o, .wb_stb_o, .wb_we_o, .wb_adr_o, .wb_dat_o, .wb_dat_i, .wb_ack_i
   );

   response_packer #(.DEPTH(DEPTH)) packer (
      .clk, .rst,
      .rsp_i        (rsp_link.receiver),
      .fifo_level_i (out_level), .fifo_wr_o (pk_wr), .fifo_data_o (pk_data)
   );

endmodule

//--- bench/wb_slave_model.sv
// wishbone target model for the bridge testbench
// 16-word memory, fixed ack latency, silent range where address bit 8 is set
`timescale 1ns/100ps
`include "wbm_settings.svh"

module wb_slave_model (
   input  logic           clk,
   input  logic           rst,
   input  logic           cyc_i,
   input  logic           stb_i,
   input  logic           we_i,
   input  wbm_pkg::word_t adr_i,
   input  wbm_pkg::word_t dat_i,
   output wbm_pkg::word_t dat_o,
   output logic           ack_o
);

   import wbm_pkg::*;

   localparam int LATENCY = 2;          // cycles from the rise of stb to ack

   word_t mem [16];                     // word address in the four low address bits
   int    wait_cnt;                     // cycles the current strobe has waited so far
   logic  answers;

   // addresses with bit 8 set are a hole in the map, the strobe just hangs there
   assign answers = cyc_i && stb_i && !adr_i[8];

   always_ff @(posedge clk) begin
      if (rst) begin
         ack_o    <= 1'b0;
         dat_o    <= '0;
         wait_cnt <= 0;
         // every word gets its own start value that depends on the full index
         for (int i = 0; i < 16; i++) mem[i] <= 32'hc0de_0000 + word_t'(i) * 32'h0000_1111;
      end else begin
         ack_o <= 1'b0;                 // ack is a single-cycle pulse
         if (answers && !ack_o) begin
            if (wait_cnt == LATENCY - 1) begin
               ack_o    <= 1'b1;
               dat_o    <= mem[adr_i[3:0]];   // old word, also on a write
               wait_cnt <= 0;
               if (we_i) mem[adr_i[3:0]] <= dat_i;
            end else begin
               wait_cnt <= wait_cnt + 1;
            end
         end else begin
            wait_cnt <= 0;              // the count starts again on the next strobe
         end
      end
   end

endmodule

//--- bench/tb_wb_bridge.sv
// testbench of the host to wishbone bridge
// stimulus table applied in passes, shadow memory prediction
// response checks, flow checks on ready_o and avail_o, watchdog and summary
`timescale 1ns/100ps
`include "wbm_settings.svh"

module tb_wb_bridge;

   import wbm_pkg::*;

   localparam int ROWS   = 10;
   localparam int PASSES = 4;           // enough packets to back the input fifo up
   localparam int TOTAL  = ROWS * PASSES;
   localparam int LIMIT  = TOTAL * (`WBM_TIMEOUT + 60);   // watchdog limit in cycles

   typedef struct packed {
      op_e   op;
      word_t addr;
      word_t mask;
      word_t data;
      logic  tmo;                       // expected result bit, set for the silent range
   } row_t;

   // rows 0 to 3 write, read, merge and read back one word
   // rows 4 and 5 hit the silent range, rows 6 and 8 use the reserved code
   // reads carry a live mask and data so that a hidden merge would show in the memory
   row_t tbl [ROWS] = '{
      '{OP_WRITE, 32'h0000_0003, 32'h0000_0000, 32'h1234_5678, 1'b0},
      '{OP_READ,  32'h0000_0003, 32'hffff_ffff, 32'h9999_9999, 1'b0},
      '{OP_RMW,   32'h0000_0003, 32'h0000_ffff, 32'haaaa_bbbb, 1'b0},
      '{OP_READ,  32'h0000_0003, 32'h0000_0000, 32'h0000_0000, 1'b0},
      '{OP_READ,  32'h0000_0104, 32'h0000_0000, 32'h0000_0000, 1'b1},
      '{OP_RMW,   32'h0000_0105, 32'hffff_ffff, 32'h5555_5555, 1'b1},
      '{OP_RSVD,  32'h0000_0003, 32'hffff_0000, 32'h7777_7777, 1'b0},
      '{OP_WRITE, 32'h0000_0009, 32'h0000_0000, 32'h0f0f_0f0f, 1'b0},
      '{OP_RSVD,  32'h0000_0009, 32'hffff_ffff, 32'h3c3c_3c3c, 1'b0},
      '{OP_READ,  32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 1'b0}
   };

   logic  clk, rst, wr_i, rd_i, ready_o, avail_o;
   word_t data_i, data_o;
   logic  wb_cyc, wb_stb, wb_we, wb_ack;
   word_t wb_adr, wb_dat_w, wb_dat_r;

   word_t shadow [16];                  // what the target memory should hold
   word_t exp_q [$];                    // expected response words in output order
   int    cycles, data_err, flow_err, n_read;
   logic  stall_seen, read_go;
   string names [4] = '{"command", "data", "address", "result"};

   wb_bridge_top wb_bridge_top_inst (
      .clk, .rst, .wr_i, .data_i, .ready_o, .rd_i, .data_o, .avail_o,
      .wb_cyc_o (wb_cyc),   .wb_stb_o (wb_stb),   .wb_we_o  (wb_we), .wb_adr_o (wb_adr),
      .wb_dat_o (wb_dat_w), .wb_dat_i (wb_dat_r), .wb_ack_i (wb_ack)
   );

   wb_slave_model slave (
      .clk, .rst, .cyc_i (wb_cyc), .stb_i (wb_stb), .we_i (wb_we), .adr_i (wb_adr),
      .dat_i (wb_dat_w), .dat_o (wb_dat_r), .ack_o (wb_ack)
   );

   always #5 clk = ~clk;

   // the run is stopped here if responses never show up
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT) begin
         $display("run stopped after %0d cycles with %0d of %0d responses read",
                  cycles, n_read, TOTAL);
         $display("test failed");
         $finish;
      end
   end

   // --------------------------------------------------
   // prediction
   // --------------------------------------------------
   // data word of one response, the shadow memory follows the bus writes
   function automatic word_t predict(input row_t r, input word_t data);
      word_t old;
      old = r.tmo ? '0 : shadow[r.addr[3:0]];   // an unanswered read gives zero
      if (r.op == OP_WRITE) begin
         if (!r.tmo) shadow[r.addr[3:0]] = data;
         return `WBM_WRITE_MARK;
      end
      if (r.op == OP_RMW && !r.tmo) shadow[r.addr[3:0]] = (old & ~r.mask) | (data & r.mask);
      return old;                       // read, reserved code and merge all return the old word
   endfunction

   // --------------------------------------------------
   // host write side
   // --------------------------------------------------
   task automatic send_word(input word_t w);
      while (!ready_o) begin
         stall_seen = 1'b1;
         read_go    = 1'b1;             // the host starts reading once the input backs up
         @(negedge clk);
      end
      wr_i   = 1'b1;
      data_i = w;
      @(negedge clk);
      wr_i   = 1'b0;
      repeat ($urandom % 3) @(negedge clk);   // random idle gap between words
   endtask

   task automatic write_all();
      row_t  r;
      cmd_t  c;
      word_t d;
      for (int p = 0; p < PASSES; p++) begin
         for (int i = 0; i < ROWS; i++) begin
            r       = tbl[i];
            d       = r.data + word_t'(p);   // fresh data on every pass
            c       = cmd_t'('0);
            c.upper = 9'(p + 1);
            c.id    = 8'(p * ROWS + i);
            c.spare = 13'h0a5c;
            c.op    = r.op;
            send_word(word_t'(c));
            send_word(r.addr);
            send_word(r.mask);
            send_word(d);
            exp_q.push_back(word_t'(c));
            exp_q.push_back(predict(r, d));
            exp_q.push_back(r.addr);
            exp_q.push_back(word_t'(r.tmo));   // timeout in bit 0, zeros above
         end
      end
      read_go = 1'b1;
   endtask

   // --------------------------------------------------
   // host read side
   // --------------------------------------------------
   task automatic read_all();
      word_t exp_w;
      while (n_read < TOTAL) begin
         @(negedge clk);
         assert (exp_q.size() != 0 || !avail_o) else begin
            flow_err++;
            $display("avail_o is high while no response is outstanding");
         end
         if (read_go && avail_o && exp_q.size() != 0) begin
            for (int k = 0; k < `WBM_PACKET_WORDS; k++) begin
               rd_i = 1'b1;
               @(negedge clk);          // word is on data_o one cycle after the pulse
               exp_w = exp_q.pop_front();
               assert (data_o == exp_w) else begin
                  data_err++;
                  $display("Error %0t ns: packet %0d %s word is %h, expected %h",
                           $time, n_read, names[k], data_o, exp_w);
               end
            end
            rd_i = 1'b0;
            n_read++;
         end
      end
   endtask

   initial begin
      clk        = 1'b0;
      rst        = 1'b1;
      wr_i       = 1'b0;
      rd_i       = 1'b0;
      data_i     = '0;
      cycles     = 0;
      data_err   = 0;
      flow_err   = 0;
      n_read     = 0;
      stall_seen = 1'b0;
      read_go    = 1'b0;
      void'($urandom(79517));
      repeat (16) @(negedge clk);
      assert (!ready_o && !avail_o && !wb_cyc) else begin
         flow_err++;
         $display("ready_o, avail_o or wb_cyc_o is not low during reset");
      end
      rst = 1'b0;
      @(negedge clk);                   // ready_o is registered and rises one cycle after reset
      assert (ready_o) else begin
         flow_err++;
         $display("ready_o did not rise after reset");
      end
      for (int i = 0; i < 16; i++) shadow[i] = slave.mem[i];   // start values of the target
      fork
         write_all();
         read_all();
      join
      repeat (20) @(negedge clk);
      assert (!avail_o && !wb_cyc) else begin
         flow_err++;
         $display("the bridge still has a response or a bus cycle after the last packet");
      end
      assert (stall_seen) else begin
         flow_err++;
         $display("ready_o never fell while the host was not reading");
      end
      for (int i = 0; i < 16; i++) begin
         assert (slave.mem[i] == shadow[i]) else begin
            data_err++;
            $display("Error %0t ns: target word %0d is %h, expected %h",
                     $time, i, slave.mem[i], shadow[i]);
         end
      end
      $display("%0d responses read, %0d value errors, %0d flow errors",
               n_read, data_err, flow_err);
      if (data_err == 0 && flow_err == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

//--- all.f
+incdir+include
rtl/wbm_pkg.sv
rtl/stage_if.sv
rtl/word_fifo.sv
rtl/command_parser.sv
rtl/bus_engine.sv
rtl/response_packer.sv
rtl/wb_bridge_top.sv
bench/wb_slave_model.sv
bench/tb_wb_bridge.sv

//--- run.sh
#!/bin/sh
# build the bridge testbench with Verilator, run it and check the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_wb_bridge \
   -o tb_wb_bridge || { echo "build failed"; exit 1; }
./obj_dir/tb_wb_bridge > sim.log 2>&1
cat sim.log
grep -qx "test passed" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
